// File: filelist.f
+incdir+include
hdl/test_regs_types_pkg.sv
hdl/test_regs_map_pkg.sv
hdl/reg_access_if.sv
hdl/reg_addr_decode.sv
hdl/debug_reg_bank.sv
hdl/reg_readback.sv
hdl/test_regs_top.sv
testbench/tb_clock_gen.sv
testbench/test_regs_asserts.sv
testbench/test_regs_tb.sv

// File: Bender.yml
package:
  name: test_regs

sources:
  - include_dirs:
      - include
    files:
      - hdl/test_regs_types_pkg.sv
      - hdl/test_regs_map_pkg.sv
      - hdl/reg_access_if.sv
      - hdl/reg_addr_decode.sv
      - hdl/debug_reg_bank.sv
      - hdl/reg_readback.sv
      - hdl/test_regs_top.sv
  - target: test
    include_dirs:
      - include
    files:
      - testbench/tb_clock_gen.sv
      - testbench/test_regs_asserts.sv
      - testbench/test_regs_tb.sv

// File: testbench/test_regs_tb.sv
//////////////////////////////////////////////////
// test register block testbench
// drives reads and writes on the access port
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "test_regs_defs.svh"

module test_regs_tb;

  localparam int TIMEOUT_CYCLES = 20;

  logic                             clk;
  logic                             srst;
  logic                             wr_en;
  test_regs_types_pkg::reg_offset_t wr_offset;
  test_regs_types_pkg::reg_word_t   wr_data;
  logic                             rd_en;
  test_regs_types_pkg::reg_offset_t rd_offset;
  test_regs_types_pkg::reg_word_t   timestamp;
  test_regs_types_pkg::reg_word_t   rd_data;
  logic                             rd_valid;
  test_regs_types_pkg::debug_bank_t debug_rw;
  integer                           seed;
  string                            test_name;

  tb_clock_gen clk_gen_i (.clk(clk), .srst(srst));

  test_regs_top dut_i (
    .clk       (clk),
    .srst      (srst),
    .wr_en     (wr_en),
    .wr_offset (wr_offset),
    .wr_data   (wr_data),
    .rd_en     (rd_en),
    .rd_offset (rd_offset),
    .timestamp (timestamp),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid),
    .debug_rw  (debug_rw)
  );

  bind test_regs_top test_regs_asserts asserts_i (
    .clk(clk), .srst(srst), .wr_en(wr_en), .wr_offset(wr_offset), .wr_data(wr_data),
    .rd_en(rd_en), .rd_offset(rd_offset), .timestamp(timestamp), .rd_data(rd_data),
    .rd_valid(rd_valid), .debug_rw(debug_rw), .scratch(scratch)
  );

  //////////////////////////////////////////////////
  // reporting and waits

  task automatic fail_and_stop();
    $display("CHECKS FAILED");
    $fatal(1, "simulation stopped at the first failure");
  endtask

  task automatic report_assert_failure();
    $display("ERROR %s: %s expected %h actual %h", test_name, dut_i.asserts_i.fail_check,
             dut_i.asserts_i.fail_exp, dut_i.asserts_i.fail_act);
    fail_and_stop();
  endtask

  task automatic wait_reset_done();
    int cycles;
    cycles = 0;
    while (srst !== 1'b0) begin
      if (cycles == 4 * TIMEOUT_CYCLES) begin
        $display("timeout: reset was never released");
        fail_and_stop();
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  task automatic wait_read_valid();
    int cycles;
    cycles = 0;
    while (rd_valid !== 1'b1) begin
      if (cycles == TIMEOUT_CYCLES) begin
        $display("timeout in %s: no rd_valid after a read", test_name);
        fail_and_stop();
      end
      @(negedge clk);
      cycles++;
    end
  endtask

  // last result of the previous test is checked on the edge in between
  task automatic start_test(input string name);
    @(negedge clk);
    test_name = name;
  endtask

  //////////////////////////////////////////////////
  // access tasks driven on the falling edge

  function automatic test_regs_types_pkg::reg_offset_t debug_offset(input int k);
    return test_regs_types_pkg::reg_offset_t'(`TR_DEBUG_BASE + k);
  endfunction

  task automatic reg_write(input test_regs_types_pkg::reg_offset_t offset,
                           input test_regs_types_pkg::reg_word_t data);
    wr_en     = 1'b1;
    wr_offset = offset;
    wr_data   = data;
    @(negedge clk);
    wr_en     = 1'b0;
  endtask

  task automatic reg_read(input test_regs_types_pkg::reg_offset_t offset);
    rd_en     = 1'b1;
    rd_offset = offset;
    @(negedge clk);
    rd_en     = 1'b0;
    wait_read_valid();
  endtask

  // read and write one word at the same edge
  task automatic write_and_read(input test_regs_types_pkg::reg_offset_t offset,
                                input test_regs_types_pkg::reg_word_t data);
    rd_en     = 1'b1;
    rd_offset = offset;
    reg_write(offset, data);
    rd_en     = 1'b0;
    wait_read_valid();
  endtask

  task automatic read_burst(input test_regs_types_pkg::reg_offset_t first, input int count,
                            input int step);
    for (int k = 0; k < count; k++) begin
      rd_en     = 1'b1;
      rd_offset = test_regs_types_pkg::reg_offset_t'(first + k * step); // one read per cycle
      @(negedge clk);
    end
    rd_en = 1'b0;
    wait_read_valid();
  endtask

  // report as soon as a check fails
  always @(posedge dut_i.asserts_i.fail_seen) begin
    report_assert_failure();
  end

  initial begin
    timestamp = 32'h0;
    forever begin
      @(negedge clk);
      timestamp = timestamp + 32'h0001_0003; // new stamp every cycle
    end
  end

  //////////////////////////////////////////////////
  // stimulus

  initial begin
    test_regs_types_pkg::reg_word_t rand_word;
    seed      = 7;
    test_name = "reset_values";
    wr_en     = 1'b0;
    wr_offset = '0;
    wr_data   = '0;
    rd_en     = 1'b0;
    rd_offset = '0;
    wait_reset_done();
    read_burst(debug_offset(0), `TR_NUM_DEBUG, 1);
    reg_read(`TR_SCRATCH_OFFSET);

    start_test("back_to_back_reads");
    read_burst(debug_offset(0), 8, 1);
    reg_read(debug_offset(3));

    start_test("random_writes");
    for (int k = 0; k < `TR_NUM_DEBUG; k++) begin
      rand_word = $random(seed);
      reg_write(debug_offset(k), rand_word);
    end
    rand_word = $random(seed);
    reg_write(`TR_SCRATCH_OFFSET, rand_word);
    read_burst(debug_offset(0), `TR_NUM_DEBUG, 1);
    reg_read(`TR_SCRATCH_OFFSET);
    rand_word = $random(seed);
    write_and_read(debug_offset(5), rand_word);
    reg_read(debug_offset(5));

    start_test("read_only_regs");
    for (int k = 0; k < 3; k++) begin
      rand_word = $random(seed);
      reg_read(test_regs_types_pkg::reg_offset_t'(k));
      reg_write(test_regs_types_pkg::reg_offset_t'(k), rand_word);
      reg_read(test_regs_types_pkg::reg_offset_t'(k));
    end

    start_test("timestamp");
    read_burst(`TR_TIMESTAMP_OFFSET, 6, 0);

    start_test("unmapped_offsets");
    reg_read(11'h100);
    reg_read(11'h7e0);
    reg_read(11'h7df);
    rand_word = $random(seed);
    reg_write(11'h100, rand_word);
    reg_write(11'h7e0, ~rand_word);
    reg_write(11'h7df, rand_word);
    reg_read(11'h7e0);
    read_burst(debug_offset(0), `TR_NUM_DEBUG, 1);
    reg_read(`TR_SCRATCH_OFFSET);

    repeat (3) @(negedge clk);
    if (dut_i.asserts_i.fail_seen) begin
      report_assert_failure();
    end else begin
      $display("ALL CHECKS PASSED");
      $finish;
    end
  end

endmodule

`default_nettype wire

// File: testbench/test_regs_asserts.sv
//////////////////////////////////////////////////
// test register checker
// shadow register model and concurrent assertions
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "test_regs_defs.svh"

module test_regs_asserts (
  input logic                      clk,
  input logic                      srst,
  input logic                      wr_en,
  input logic [`TR_OFFSET_W-1:0]   wr_offset,
  input logic [`TR_DATA_W-1:0]     wr_data,
  input logic                      rd_en,
  input logic [`TR_OFFSET_W-1:0]   rd_offset,
  input logic [`TR_DATA_W-1:0]     timestamp,
  input logic [`TR_DATA_W-1:0]     rd_data,
  input logic                      rd_valid,
  input logic [`TR_NUM_DEBUG-1:0][`TR_DATA_W-1:0] debug_rw,
  input logic [`TR_DATA_W-1:0]     scratch
);

  logic [`TR_NUM_DEBUG-1:0][31:0] shadow_dbg;
  logic [31:0]                    shadow_scr;
  logic [31:0]                    exp_rd_q;   // expected data for the next rd_valid
  logic                           rd_en_q;
  logic                           fail_seen = 1'b0; // watched by the testbench
  string                          fail_check;
  logic [31:0]                    fail_exp;
  logic [31:0]                    fail_act;

  // read value by the register map, zero where nothing is mapped
  function automatic logic [31:0] expected_read(input logic [`TR_OFFSET_W-1:0] offset);
    logic [31:0] value;
    value = 32'h0;
    if (offset == 11'h000) value = {`TR_MAJOR_VERSION, `TR_MINOR_VERSION, `TR_REVISION_NUM};
    else if (offset == 11'h001) value = `TR_DEBUG_REVISION;
    else if (offset == 11'h002) value = timestamp;
    else if (offset >= 11'h7c0 && offset <= 11'h7de) value = shadow_dbg[offset - 11'h7c0];
    else if (offset == 11'h7ff) value = shadow_scr;
    return value;
  endfunction

  task automatic record_fail(input string what, input logic [31:0] exp, input logic [31:0] act);
    fail_seen  = 1'b1;
    fail_check = what;
    fail_exp   = exp;
    fail_act   = act;
    $error("%s: expected %h, got %h", what, exp, act);
  endtask

  //////////////////////////////////////////////////
  // shadow model

  always @(posedge clk) begin
    if (srst) begin
      for (int k = 0; k < `TR_NUM_DEBUG; k++) begin
        shadow_dbg[k] <= (k == 1 || k == 2) ? 32'h1 : 32'h0; // words 1 and 2 come up set
      end
      shadow_scr <= 32'h3333_cccc;
      rd_en_q    <= 1'b0;
      exp_rd_q   <= 32'h0;
    end else begin
      if (wr_en && wr_offset >= 11'h7c0 && wr_offset <= 11'h7de)
        shadow_dbg[wr_offset - 11'h7c0] <= wr_data;
      if (wr_en && wr_offset == 11'h7ff) shadow_scr <= wr_data;
      rd_en_q <= rd_en;
      if (rd_en) exp_rd_q <= expected_read(rd_offset); // old value on a same-edge write
    end
  end

  //////////////////////////////////////////////////
  // assertions

  reset_idle: assert property (@(posedge clk) srst |=> (!rd_valid && rd_data == 32'h0))
    else record_fail("read port after reset", 32'h0, $sampled(rd_data));

  valid_follows_read: assert property (@(posedge clk) disable iff (srst)
    rd_valid == rd_en_q)
    else record_fail("rd_valid", {31'h0, $sampled(rd_en_q)}, {31'h0, $sampled(rd_valid)});

  read_data_matches: assert property (@(posedge clk) disable iff (srst)
    rd_valid |-> rd_data == exp_rd_q)
    else record_fail("rd_data", $sampled(exp_rd_q), $sampled(rd_data));

  scratch_matches: assert property (@(posedge clk) disable iff (srst) scratch == shadow_scr)
    else record_fail("scratch", $sampled(shadow_scr), $sampled(scratch));

  for (genvar k = 0; k < `TR_NUM_DEBUG; k++) begin : g_debug_word
    debug_word_matches: assert property (@(posedge clk) disable iff (srst)
      debug_rw[k] == shadow_dbg[k])
      else record_fail($sformatf("debug_rw[%0d]", k), $sampled(shadow_dbg[k]),
                       $sampled(debug_rw[k]));
  end

endmodule

`default_nettype wire

// File: testbench/tb_clock_gen.sv
//////////////////////////////////////////////////
// testbench clock and reset
// 10 ns clock, reset held for the first 8 edges
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module tb_clock_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 8
) (
  output logic clk,
  output logic srst
);

  initial begin
    clk = 1'b0;
    forever #(PERIOD_NS / 2) clk = ~clk;
  end

  initial begin
    srst = 1'b1;
    repeat (RST_CYCLES) @(posedge clk);
    @(negedge clk); // release away from the rising edge
    srst = 1'b0;
  end

endmodule

`default_nettype wire

// File: hdl/test_regs_top.sv
//////////////////////////////////////////////////
// test and debug register block
// decode, register bank and registered readback
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

module test_regs_top (
  input  logic                             clk,
  input  logic                             srst,
  input  logic                             wr_en,
  input  test_regs_types_pkg::reg_offset_t wr_offset,
  input  test_regs_types_pkg::reg_word_t   wr_data,
  input  logic                             rd_en,
  input  test_regs_types_pkg::reg_offset_t rd_offset,
  input  test_regs_types_pkg::reg_word_t   timestamp,
  output test_regs_types_pkg::reg_word_t   rd_data,
  output logic                             rd_valid,
  output test_regs_types_pkg::debug_bank_t debug_rw
);

  reg_access_if acc_if ();

  test_regs_types_pkg::reg_word_t scratch; // bank to readback only

  //////////////////////////////////////////////////
  // decode

  reg_addr_decode decode_i (
    .wr_en     (wr_en),
    .wr_offset (wr_offset),
    .wr_data   (wr_data),
    .rd_en     (rd_en),
    .rd_offset (rd_offset),
    .acc       (acc_if.decoder)
  );

  //////////////////////////////////////////////////
  // storage and readback

  debug_reg_bank bank_i (
    .clk      (clk),
    .srst     (srst),
    .acc      (acc_if.bank),
    .debug_rw (debug_rw),
    .scratch  (scratch)
  );

  reg_readback readback_i (
    .clk       (clk),
    .srst      (srst),
    .acc       (acc_if.readback),
    .debug_rw  (debug_rw),
    .scratch   (scratch),
    .timestamp (timestamp),
    .rd_data   (rd_data),
    .rd_valid  (rd_valid)
  );

endmodule

`default_nettype wire

// File: hdl/reg_readback.sv
//////////////////////////////////////////////////
// register readback
// selects the read source, registers data and valid
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "test_regs_defs.svh"

module reg_readback (
  input  logic                             clk,
  input  logic                             srst,
  reg_access_if.readback                   acc,
  input  test_regs_types_pkg::debug_bank_t debug_rw,
  input  test_regs_types_pkg::reg_word_t   scratch,
  input  test_regs_types_pkg::reg_word_t   timestamp,
  output test_regs_types_pkg::reg_word_t   rd_data,
  output logic                             rd_valid
);

  test_regs_map_pkg::version_word_t version_w;
  test_regs_types_pkg::reg_word_t   rd_mux;
  test_regs_types_pkg::reg_word_t   rd_data_q;
  logic                             rd_valid_q;

  // fixed at build time
  assign version_w.major    = `TR_MAJOR_VERSION;
  assign version_w.minor    = `TR_MINOR_VERSION;
  assign version_w.revision = `TR_REVISION_NUM;

  //////////////////////////////////////////////////
  // source select

  always_comb begin
    case (acc.rd_src)
      test_regs_map_pkg::RD_VERSION:   rd_mux = version_w;
      test_regs_map_pkg::RD_DBG_REV:   rd_mux = `TR_DEBUG_REVISION;
      test_regs_map_pkg::RD_TIMESTAMP: rd_mux = timestamp; // value at the read edge
      test_regs_map_pkg::RD_DEBUG:     rd_mux = debug_rw[acc.rd_index];
      test_regs_map_pkg::RD_SCRATCH:   rd_mux = scratch;
      default:                         rd_mux = '0; // unmapped
    endcase
  end

  //////////////////////////////////////////////////
  // result stage, one cycle after rd_en

  always_ff @(posedge clk) begin
    if (srst) begin
      rd_valid_q <= 1'b0;
      rd_data_q  <= '0;
    end else begin
      rd_valid_q <= acc.rd_strobe; // one valid per strobe
      if (acc.rd_strobe) begin
        rd_data_q <= rd_mux; // old value on a same-edge write
      end
    end
  end

  assign rd_data  = rd_data_q;
  assign rd_valid = rd_valid_q;

endmodule

`default_nettype wire

// File: hdl/debug_reg_bank.sv
//////////////////////////////////////////////////
// debug register bank
// 31 read-write debug controls and the scratch word
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "test_regs_defs.svh"

module debug_reg_bank (
  input  logic                             clk,
  input  logic                             srst,
  reg_access_if.bank                       acc,
  output test_regs_types_pkg::debug_bank_t debug_rw,
  output test_regs_types_pkg::reg_word_t   scratch
);

  // one bit per debug word, set means reset to one
  localparam logic [`TR_NUM_DEBUG-1:0] RST_MASK = `TR_DEBUG_RST_MASK;

  test_regs_types_pkg::debug_bank_t debug_q;
  test_regs_types_pkg::reg_word_t   scratch_q;

  //////////////////////////////////////////////////
  // debug words

  always_ff @(posedge clk) begin
    if (srst) begin
      for (int k = 0; k < `TR_NUM_DEBUG; k++) begin
        debug_q[k] <= test_regs_types_pkg::reg_word_t'(RST_MASK[k]);
      end
    end else if (acc.wr_debug) begin
      debug_q[acc.wr_index] <= acc.wr_data; // index always inside window
    end
  end

  //////////////////////////////////////////////////
  // scratch word

  always_ff @(posedge clk) begin
    if (srst) begin
      scratch_q <= `TR_SCRATCH_RST;
    end else if (acc.wr_scratch) begin
      scratch_q <= acc.wr_data;
    end
  end

  assign debug_rw = debug_q; // controls leave the block directly
  assign scratch  = scratch_q;

endmodule

`default_nettype wire

// File: hdl/reg_addr_decode.sv
//////////////////////////////////////////////////
// register address decode
// maps raw offsets to write strobes and read sources
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

`include "test_regs_defs.svh"

module reg_addr_decode (
  input  logic                             wr_en,
  input  test_regs_types_pkg::reg_offset_t wr_offset,
  input  test_regs_types_pkg::reg_word_t   wr_data,
  input  logic                             rd_en,
  input  test_regs_types_pkg::reg_offset_t rd_offset,
  reg_access_if.decoder                    acc
);

  //////////////////////////////////////////////////
  // debug window helpers

  // true for base .. base + 30, 7df and up are unmapped
  function automatic logic in_debug_window(test_regs_types_pkg::reg_offset_t offset);
    return (offset >= `TR_DEBUG_BASE) &&
           (offset < (`TR_DEBUG_BASE + `TR_NUM_DEBUG));
  endfunction

  function automatic test_regs_types_pkg::debug_index_t debug_index(
    test_regs_types_pkg::reg_offset_t offset
  );
    test_regs_types_pkg::reg_offset_t delta;
    delta = offset - `TR_DEBUG_BASE;
    return test_regs_types_pkg::debug_index_t'(delta); // low bits only
  endfunction

  //////////////////////////////////////////////////
  // write decode, read-only and unmapped offsets drop out

  assign acc.wr_debug   = wr_en && in_debug_window(wr_offset);
  assign acc.wr_scratch = wr_en && (wr_offset == `TR_SCRATCH_OFFSET);
  assign acc.wr_index   = debug_index(wr_offset);
  assign acc.wr_data    = wr_data;

  //////////////////////////////////////////////////
  // read decode

  assign acc.rd_strobe = rd_en;
  assign acc.rd_index  = debug_index(rd_offset);

  always_comb begin
    if (rd_offset == `TR_VERSION_OFFSET) begin
      acc.rd_src = test_regs_map_pkg::RD_VERSION;
    end else if (rd_offset == `TR_DBG_REV_OFFSET) begin
      acc.rd_src = test_regs_map_pkg::RD_DBG_REV;
    end else if (rd_offset == `TR_TIMESTAMP_OFFSET) begin
      acc.rd_src = test_regs_map_pkg::RD_TIMESTAMP;
    end else if (in_debug_window(rd_offset)) begin
      acc.rd_src = test_regs_map_pkg::RD_DEBUG;
    end else if (rd_offset == `TR_SCRATCH_OFFSET) begin
      acc.rd_src = test_regs_map_pkg::RD_SCRATCH;
    end else begin
      acc.rd_src = test_regs_map_pkg::RD_NONE; // reads back zero
    end
  end

endmodule

`default_nettype wire

// File: hdl/reg_access_if.sv
//////////////////////////////////////////////////
// decoded register access
// write targets and read selects from the decoder
//////////////////////////////////////////////////

`timescale 1ns/1ps
`default_nettype none

interface reg_access_if;

  // write side
  logic                              wr_debug;   // write one debug word
  logic                              wr_scratch; // write scratch
  test_regs_types_pkg::debug_index_t wr_index;
  test_regs_types_pkg::reg_word_t    wr_data;

  // read side
  logic                              rd_strobe;  // one per rd_en
  test_regs_map_pkg::rd_src_e        rd_src;
  test_regs_types_pkg::debug_index_t rd_index;

  modport decoder (
    output wr_debug, wr_scratch, wr_index, wr_data,
    output rd_strobe, rd_src, rd_index
  );

  modport bank (
    input wr_debug, wr_scratch, wr_index, wr_data
  );

  modport readback (
    input rd_strobe, rd_src, rd_index
  );

endinterface

`default_nettype wire

// File: hdl/test_regs_map_pkg.sv
//////////////////////////////////////////////////
// test register map types
// read source select and version word layout
//////////////////////////////////////////////////

`default_nettype none

package test_regs_map_pkg;

  // where a read takes its data from
  typedef enum logic [2:0] {
    RD_NONE      = 3'd0, // unmapped, reads as zero
    RD_VERSION   = 3'd1,
    RD_DBG_REV   = 3'd2,
    RD_TIMESTAMP = 3'd3,
    RD_DEBUG     = 3'd4, // indexed debug word
    RD_SCRATCH   = 3'd5
  } rd_src_e;

  // version register, major in the top byte
  typedef struct packed {
    logic [7:0]  major;
    logic [7:0]  minor;
    logic [15:0] revision;
  } version_word_t;

endpackage

`default_nettype wire

// File: hdl/test_regs_types_pkg.sv
//////////////////////////////////////////////////
// test register data path types
// words, offsets and the debug bank
//////////////////////////////////////////////////

`default_nettype none

`include "test_regs_defs.svh"

package test_regs_types_pkg;

  // one register word
  typedef logic [`TR_DATA_W-1:0] reg_word_t;

  // word offset on the access port
  typedef logic [`TR_OFFSET_W-1:0] reg_offset_t;

  // selects one debug word, 5 bits for 31 words
  typedef logic [$clog2(`TR_NUM_DEBUG)-1:0] debug_index_t;

  // whole debug bank, word k in slice k
  typedef reg_word_t [`TR_NUM_DEBUG-1:0] debug_bank_t;

endpackage

`default_nettype wire

// File: include/test_regs_defs.svh
//////////////////////////////////////////////////
// test register block build constants
// widths, register map offsets, identity and reset values
//////////////////////////////////////////////////

`ifndef TEST_REGS_DEFS_SVH
`define TEST_REGS_DEFS_SVH

`default_nettype none

//////////////////////////////////////////////////
// widths and sizes

`define TR_DATA_W   32 // register word
`define TR_OFFSET_W 11 // word offset, byte address bits [12:2]
`define TR_NUM_DEBUG 31 // debug words in the bank

//////////////////////////////////////////////////
// word offsets

`define TR_VERSION_OFFSET   11'h000 // read only
`define TR_DBG_REV_OFFSET   11'h001 // read only
`define TR_TIMESTAMP_OFFSET 11'h002 // read only, from outside
`define TR_DEBUG_BASE       11'h7c0 // debug word k at base + k
`define TR_SCRATCH_OFFSET   11'h7ff

//////////////////////////////////////////////////
// build identity

`define TR_MAJOR_VERSION  8'h01
`define TR_MINOR_VERSION  8'h02
`define TR_REVISION_NUM   16'h0007
`define TR_DEBUG_REVISION 32'h0000_0000 // nonzero only on debug builds

//////////////////////////////////////////////////
// reset values

// words 1 and 2 come up as one, the rest as zero
`define TR_DEBUG_RST_MASK 31'h0000_0006
`define TR_SCRATCH_RST    32'h3333_cccc // easy to spot on a readback

`default_nettype wire

`endif
